/* source/mips_pkg.sv */
`default_nettype none

package mips_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [31:0] inst_t;
	typedef logic [3:0]  alu_op_t;

	// Primary opcodes
	localparam logic [5:0] OP_SPECIAL = 6'b000000;
	localparam logic [5:0] OP_ADDIU   = 6'b001001;
	localparam logic [5:0] OP_ANDI    = 6'b001100;
	localparam logic [5:0] OP_ORI     = 6'b001101;
	localparam logic [5:0] OP_XORI    = 6'b001110;
	localparam logic [5:0] OP_LUI     = 6'b001111;

	// SPECIAL function field
	localparam logic [5:0] FN_SLL  = 6'b000000;
	localparam logic [5:0] FN_SRL  = 6'b000010;
	localparam logic [5:0] FN_ADDU = 6'b100001;
	localparam logic [5:0] FN_SUBU = 6'b100011;
	localparam logic [5:0] FN_AND  = 6'b100100;
	localparam logic [5:0] FN_OR   = 6'b100101;
	localparam logic [5:0] FN_XOR  = 6'b100110;
	localparam logic [5:0] FN_NOR  = 6'b100111;
	localparam logic [5:0] FN_SLT  = 6'b101010;

	// Internal ALU operations
	// ALU_LUI is the highest legal code
	localparam alu_op_t ALU_ADD = 4'd0;
	localparam alu_op_t ALU_SUB = 4'd1;
	localparam alu_op_t ALU_AND = 4'd2;
	localparam alu_op_t ALU_OR  = 4'd3;
	localparam alu_op_t ALU_XOR = 4'd4;
	localparam alu_op_t ALU_NOR = 4'd5;
	localparam alu_op_t ALU_SLT = 4'd6;
	localparam alu_op_t ALU_SLL = 4'd7;
	localparam alu_op_t ALU_SRL = 4'd8;
	localparam alu_op_t ALU_LUI = 4'd9;

endpackage

`default_nettype wire

/* source/regfile.sv */
`default_nettype none

module regfile (
	input  logic                clk,
	input  logic                rst_i,

	input  logic                we_i,
	input  mips_pkg::reg_addr_t waddr_i,
	input  mips_pkg::word_t     wdata_i,

	input  mips_pkg::reg_addr_t raddr1_i,
	input  mips_pkg::reg_addr_t raddr2_i,
	output mips_pkg::word_t     rdata1_o,
	output mips_pkg::word_t     rdata2_o
);

	mips_pkg::word_t regs [32];

	// Zero register, then same-cycle write bypass, then storage
	function automatic mips_pkg::word_t read_port(mips_pkg::reg_addr_t addr,
			mips_pkg::word_t stored);
		if (addr == '0)
			return '0;
		if (we_i && waddr_i == addr)
			return wdata_i;
		return stored;
	endfunction

	always_ff @(posedge clk) begin
		if (rst_i) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (we_i && waddr_i != '0) begin
			regs[waddr_i] <= wdata_i;
		end
	end

	always_comb begin
		rdata1_o = read_port(raddr1_i, regs[raddr1_i]);
		rdata2_o = read_port(raddr2_i, regs[raddr2_i]);
	end

	// Decode drops r0 destinations long before they reach the write port
	assert property (@(posedge clk) disable iff (rst_i)
		we_i |-> waddr_i != '0)
		else $error("regfile: write strobe with register 0 as target");

endmodule

`default_nettype wire

/* source/decode_stage.sv */
`default_nettype none

module decode_stage (
	input  logic                clk,
	input  logic                rst_i,
	input  logic                advance_i,

	input  logic                inst_valid_i,
	input  mips_pkg::inst_t     inst_i,

	output mips_pkg::reg_addr_t rs_addr_o,
	output mips_pkg::reg_addr_t rt_addr_o,
	input  mips_pkg::word_t     rs_data_i,
	input  mips_pkg::word_t     rt_data_i,

	input  logic                ex_valid_i,
	input  mips_pkg::reg_addr_t ex_dest_i,
	input  mips_pkg::word_t     ex_result_i,

	input  logic                wb_valid_i,
	input  mips_pkg::reg_addr_t wb_dest_i,
	input  mips_pkg::word_t     wb_result_i,

	output logic                dx_valid_o,
	output mips_pkg::alu_op_t   dx_op_o,
	output mips_pkg::word_t     dx_a_o,
	output mips_pkg::word_t     dx_b_o,
	output logic [4:0]          dx_shamt_o,
	output mips_pkg::reg_addr_t dx_dest_o
);

	// Input port register
	logic                inst_valid_q;
	mips_pkg::inst_t     inst_q;

	logic [5:0]          opcode;
	logic [5:0]          funct;
	mips_pkg::reg_addr_t rs;
	mips_pkg::reg_addr_t rt;
	mips_pkg::reg_addr_t rd;
	logic [15:0]         imm;

	mips_pkg::alu_op_t   op;
	mips_pkg::reg_addr_t dest;
	logic                legal;
	logic                use_rs;
	logic                use_rt;
	logic                imm_sext;
	mips_pkg::word_t     imm_ext;
	mips_pkg::word_t     rs_val;
	mips_pkg::word_t     rt_val;

	// Held operands plus what is needed to patch them one cycle later
	mips_pkg::word_t     a_q;
	mips_pkg::word_t     b_q;
	mips_pkg::reg_addr_t rs_q;
	mips_pkg::reg_addr_t rt_q;
	logic                use_rs_q;
	logic                use_rt_q;

	assign opcode = inst_q[31:26];
	assign rs     = inst_q[25:21];
	assign rt     = inst_q[20:16];
	assign rd     = inst_q[15:11];
	assign funct  = inst_q[5:0];
	assign imm    = inst_q[15:0];

	assign rs_addr_o = rs;
	assign rt_addr_o = rt;

	// Execute register wins over writeback register, which wins over regfile
	function automatic mips_pkg::word_t pick(mips_pkg::reg_addr_t addr,
			mips_pkg::word_t rf_val);
		if (ex_valid_i && ex_dest_i == addr)
			return ex_result_i;
		if (wb_valid_i && wb_dest_i == addr)
			return wb_result_i;
		return rf_val;
	endfunction

	// Immediate predecessor only reaches the execute register now
	function automatic mips_pkg::word_t late(logic used, mips_pkg::reg_addr_t addr,
			mips_pkg::word_t held);
		if (used && ex_valid_i && ex_dest_i == addr)
			return ex_result_i;
		return held;
	endfunction

	always_comb begin
		op       = mips_pkg::ALU_ADD;
		dest     = rd;
		legal    = 1'b0;
		use_rs   = 1'b0;
		use_rt   = 1'b0;
		imm_sext = 1'b0;
		case (opcode)
			mips_pkg::OP_SPECIAL: begin
				legal  = 1'b1;
				use_rs = 1'b1;
				use_rt = 1'b1;
				case (funct)
					mips_pkg::FN_ADDU: op = mips_pkg::ALU_ADD;
					mips_pkg::FN_SUBU: op = mips_pkg::ALU_SUB;
					mips_pkg::FN_AND:  op = mips_pkg::ALU_AND;
					mips_pkg::FN_OR:   op = mips_pkg::ALU_OR;
					mips_pkg::FN_XOR:  op = mips_pkg::ALU_XOR;
					mips_pkg::FN_NOR:  op = mips_pkg::ALU_NOR;
					mips_pkg::FN_SLT:  op = mips_pkg::ALU_SLT;
					mips_pkg::FN_SLL: begin
						op     = mips_pkg::ALU_SLL;
						use_rs = 1'b0;
					end
					mips_pkg::FN_SRL: begin
						op     = mips_pkg::ALU_SRL;
						use_rs = 1'b0;
					end
					default: legal = 1'b0;
				endcase
			end
			mips_pkg::OP_ADDIU: begin
				legal    = 1'b1;
				use_rs   = 1'b1;
				imm_sext = 1'b1;
				dest     = rt;
			end
			mips_pkg::OP_ANDI: begin
				legal  = 1'b1;
				use_rs = 1'b1;
				op     = mips_pkg::ALU_AND;
				dest   = rt;
			end
			mips_pkg::OP_ORI: begin
				legal  = 1'b1;
				use_rs = 1'b1;
				op     = mips_pkg::ALU_OR;
				dest   = rt;
			end
			mips_pkg::OP_XORI: begin
				legal  = 1'b1;
				use_rs = 1'b1;
				op     = mips_pkg::ALU_XOR;
				dest   = rt;
			end
			mips_pkg::OP_LUI: begin
				legal = 1'b1;
				op    = mips_pkg::ALU_LUI;
				dest  = rt;
			end
			default: legal = 1'b0;
		endcase
	end

	always_comb begin
		imm_ext = imm_sext ? {{16{imm[15]}}, imm} : {16'h0000, imm};
		rs_val  = pick(rs, rs_data_i);
		rt_val  = pick(rt, rt_data_i);
		dx_a_o  = late(use_rs_q, rs_q, a_q);
		dx_b_o  = late(use_rt_q, rt_q, b_q);
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			inst_valid_q <= 1'b0;
			dx_valid_o   <= 1'b0;
		end else if (advance_i) begin
			inst_valid_q <= inst_valid_i;
			dx_valid_o   <= inst_valid_q && legal && dest != '0;
		end
	end

	always_ff @(posedge clk) begin
		if (advance_i) begin
			inst_q     <= inst_i;
			dx_op_o    <= op;
			dx_shamt_o <= inst_q[10:6];
			dx_dest_o  <= dest;
			a_q        <= use_rs ? rs_val : '0;
			b_q        <= use_rt ? rt_val : imm_ext;
			rs_q       <= rs;
			rt_q       <= rt;
			use_rs_q   <= use_rs;
			use_rt_q   <= use_rt;
		end
	end

	assert property (@(posedge clk) disable iff (rst_i)
		dx_valid_o |-> dx_op_o <= mips_pkg::ALU_LUI)
		else $error("decode: valid entry with bad ALU op");

endmodule

`default_nettype wire

/* source/execute_stage.sv */
`default_nettype none

module execute_stage (
	input  logic                clk,
	input  logic                rst_i,
	input  logic                advance_i,

	input  logic                dx_valid_i,
	input  mips_pkg::alu_op_t   dx_op_i,
	input  mips_pkg::word_t     dx_a_i,
	input  mips_pkg::word_t     dx_b_i,
	input  logic [4:0]          dx_shamt_i,
	input  mips_pkg::reg_addr_t dx_dest_i,

	output logic                ex_valid_o,
	output mips_pkg::reg_addr_t ex_dest_o,
	output mips_pkg::word_t     ex_result_o
);

	mips_pkg::word_t result;

	// All arithmetic wraps at 32 bits
	always_comb begin
		case (dx_op_i)
			mips_pkg::ALU_ADD:
				result = dx_a_i + dx_b_i;
			mips_pkg::ALU_SUB:
				result = dx_a_i - dx_b_i;
			mips_pkg::ALU_AND:
				result = dx_a_i & dx_b_i;
			mips_pkg::ALU_OR:
				result = dx_a_i | dx_b_i;
			mips_pkg::ALU_XOR:
				result = dx_a_i ^ dx_b_i;
			mips_pkg::ALU_NOR:
				result = ~(dx_a_i | dx_b_i);
			mips_pkg::ALU_SLT:
				result = {31'b0, $signed(dx_a_i) < $signed(dx_b_i)};
			// Shifts take rt through operand B
			mips_pkg::ALU_SLL:
				result = dx_b_i << dx_shamt_i;
			mips_pkg::ALU_SRL:
				result = dx_b_i >> dx_shamt_i;
			mips_pkg::ALU_LUI:
				result = {dx_b_i[15:0], 16'h0000};
			default:
				result = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			ex_valid_o <= 1'b0;
		end else if (advance_i) begin
			ex_valid_o <= dx_valid_i;
		end
	end

	always_ff @(posedge clk) begin
		if (advance_i) begin
			ex_dest_o   <= dx_dest_i;
			ex_result_o <= result;
		end
	end

endmodule

`default_nettype wire

/* source/writeback_stage.sv */
`default_nettype none

module writeback_stage (
	input  logic                clk,
	input  logic                rst_i,

	input  logic                ex_valid_i,
	input  mips_pkg::reg_addr_t ex_dest_i,
	input  mips_pkg::word_t     ex_result_i,

	output logic                advance_o,

	output logic                wb_valid_o,
	output mips_pkg::reg_addr_t wb_addr_o,
	output mips_pkg::word_t     wb_data_o,
	input  logic                wb_ready_i,

	output logic                rf_we_o
);

	// Whole pipeline freezes while a result waits on the consumer
	assign advance_o = !wb_valid_o || wb_ready_i;

	// Architectural write happens with the output handshake
	assign rf_we_o = wb_valid_o && wb_ready_i;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			wb_valid_o <= 1'b0;
		end else if (advance_o) begin
			wb_valid_o <= ex_valid_i;
		end
	end

	always_ff @(posedge clk) begin
		if (advance_o) begin
			wb_addr_o <= ex_dest_i;
			wb_data_o <= ex_result_i;
		end
	end

	assert property (@(posedge clk) disable iff (rst_i)
		wb_valid_o && !wb_ready_i |=>
			wb_valid_o && $stable(wb_addr_o) && $stable(wb_data_o))
		else $error("writeback: output changed while stalled");

endmodule

`default_nettype wire

/* source/mips_core.sv */
`default_nettype none

module mips_core (
	input  logic        clk,
	input  logic        rst_i,

	input  logic        inst_valid_i,
	input  logic [31:0] inst_i,
	output logic        inst_ready_o,

	output logic        wb_valid_o,
	output logic [4:0]  wb_addr_o,
	output logic [31:0] wb_data_o,
	input  logic        wb_ready_i
);

	logic        advance;

	logic [4:0]  rs_addr;
	logic [4:0]  rt_addr;
	logic [31:0] rs_data;
	logic [31:0] rt_data;

	logic        dx_valid;
	logic [3:0]  dx_op;
	logic [31:0] dx_a;
	logic [31:0] dx_b;
	logic [4:0]  dx_shamt;
	logic [4:0]  dx_dest;

	logic        ex_valid;
	logic [4:0]  ex_dest;
	logic [31:0] ex_result;

	logic        rf_we;

	assign inst_ready_o = advance;

	regfile regfile_inst (
		.clk      (clk),
		.rst_i    (rst_i),
		.we_i     (rf_we),
		.waddr_i  (wb_addr_o),
		.wdata_i  (wb_data_o),
		.raddr1_i (rs_addr),
		.raddr2_i (rt_addr),
		.rdata1_o (rs_data),
		.rdata2_o (rt_data)
	);

	decode_stage decode_inst (
		.clk          (clk),
		.rst_i        (rst_i),
		.advance_i    (advance),
		.inst_valid_i (inst_valid_i),
		.inst_i       (inst_i),
		.rs_addr_o    (rs_addr),
		.rt_addr_o    (rt_addr),
		.rs_data_i    (rs_data),
		.rt_data_i    (rt_data),
		.ex_valid_i   (ex_valid),
		.ex_dest_i    (ex_dest),
		.ex_result_i  (ex_result),
		.wb_valid_i   (wb_valid_o),
		.wb_dest_i    (wb_addr_o),
		.wb_result_i  (wb_data_o),
		.dx_valid_o   (dx_valid),
		.dx_op_o      (dx_op),
		.dx_a_o       (dx_a),
		.dx_b_o       (dx_b),
		.dx_shamt_o   (dx_shamt),
		.dx_dest_o    (dx_dest)
	);

	execute_stage execute_inst (
		.clk         (clk),
		.rst_i       (rst_i),
		.advance_i   (advance),
		.dx_valid_i  (dx_valid),
		.dx_op_i     (dx_op),
		.dx_a_i      (dx_a),
		.dx_b_i      (dx_b),
		.dx_shamt_i  (dx_shamt),
		.dx_dest_i   (dx_dest),
		.ex_valid_o  (ex_valid),
		.ex_dest_o   (ex_dest),
		.ex_result_o (ex_result)
	);

	writeback_stage writeback_inst (
		.clk         (clk),
		.rst_i       (rst_i),
		.ex_valid_i  (ex_valid),
		.ex_dest_i   (ex_dest),
		.ex_result_i (ex_result),
		.advance_o   (advance),
		.wb_valid_o  (wb_valid_o),
		.wb_addr_o   (wb_addr_o),
		.wb_data_o   (wb_data_o),
		.wb_ready_i  (wb_ready_i),
		.rf_we_o     (rf_we)
	);

endmodule

`default_nettype wire

/* verif/wb_checker.sv */
`default_nettype none

module wb_checker (
	input  logic        clk,
	input  logic        rst_i,

	input  logic        inst_valid_i,
	input  logic [31:0] inst_i,
	input  logic        inst_ready_i,

	input  logic        wb_valid_i,
	input  logic [4:0]  wb_addr_i,
	input  logic [31:0] wb_data_i,
	input  logic        wb_ready_i,

	input  logic        end_i,
	output int          pending_o,
	output int          errors_o,
	output int          checks_o
);
	timeunit 1ns;
	timeprecision 100ps;

	// Architectural register state, in program order
	mips_pkg::word_t     model [32];

	mips_pkg::reg_addr_t exp_addr [$];
	mips_pkg::word_t     exp_data [$];
	int                  exp_adv [$];

	int                  adv_count;
	int                  idle_count;
	int                  errors;
	int                  checks;
	logic                seen_inst;
	logic                stall_q;
	mips_pkg::reg_addr_t addr_q;
	mips_pkg::word_t     data_q;

	// Returns 1 when the instruction writes a nonzero register
	function automatic logic reference_exec(input mips_pkg::inst_t inst,
			output mips_pkg::reg_addr_t dest, output mips_pkg::word_t value);
		logic [5:0]      opcode;
		logic [5:0]      funct;
		logic [15:0]     imm;
		logic [4:0]      sa;
		mips_pkg::word_t a;
		mips_pkg::word_t b;
		logic            ok;
		opcode = inst[31:26];
		funct  = inst[5:0];
		imm    = inst[15:0];
		sa     = inst[10:6];
		a      = model[inst[25:21]];
		b      = model[inst[20:16]];
		dest   = inst[20:16];
		value  = '0;
		ok     = 1'b1;
		case (opcode)
			mips_pkg::OP_SPECIAL: begin
				dest = inst[15:11];
				case (funct)
					mips_pkg::FN_ADDU: value = a + b;
					mips_pkg::FN_SUBU: value = a - b;
					mips_pkg::FN_AND:  value = a & b;
					mips_pkg::FN_OR:   value = a | b;
					mips_pkg::FN_XOR:  value = a ^ b;
					mips_pkg::FN_NOR:  value = ~(a | b);
					mips_pkg::FN_SLT:  value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					mips_pkg::FN_SLL:  value = b << sa;
					mips_pkg::FN_SRL:  value = b >> sa;
					default:           ok = 1'b0;
				endcase
			end
			mips_pkg::OP_ADDIU: value = a + {{16{imm[15]}}, imm};
			mips_pkg::OP_ANDI:  value = a & {16'h0000, imm};
			mips_pkg::OP_ORI:   value = a | {16'h0000, imm};
			mips_pkg::OP_XORI:  value = a ^ {16'h0000, imm};
			mips_pkg::OP_LUI:   value = {imm, 16'h0000};
			default:            ok = 1'b0;
		endcase
		return ok && dest != 5'd0;
	endfunction

	task automatic compare_word(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("mismatch %s: expected %h, got %h", name, expected, actual);
		end
	endtask

	always @(posedge clk) begin
		mips_pkg::reg_addr_t dest;
		mips_pkg::word_t     value;
		mips_pkg::reg_addr_t want_addr;
		mips_pkg::word_t     want_data;
		int                  accepted_at;
		if (rst_i) begin
			for (int i = 0; i < 32; i++)
				model[i] = '0;
			exp_addr.delete();
			exp_data.delete();
			exp_adv.delete();
			adv_count  = 0;
			idle_count = 0;
			seen_inst  = 1'b0;
			stall_q    = 1'b0;
		end else begin
			// Idle pipeline straight out of reset
			if (!seen_inst) begin
				compare_word("wb_valid_o", 32'd0, {31'b0, wb_valid_i});
				compare_word("inst_ready_o", 32'd1, {31'b0, inst_ready_i});
			end
			compare_word("inst_ready_o", {31'b0, !wb_valid_i || wb_ready_i},
				{31'b0, inst_ready_i});
			if (stall_q) begin
				compare_word("wb_valid_o", 32'd1, {31'b0, wb_valid_i});
				compare_word("wb_addr_o", {27'b0, addr_q}, {27'b0, wb_addr_i});
				compare_word("wb_data_o", data_q, wb_data_i);
			end
			if (wb_valid_i && wb_ready_i) begin
				idle_count = 0;
				if (exp_addr.size() == 0) begin
					errors++;
					$display("unexpected writeback beat to r%0d with data %h",
						wb_addr_i, wb_data_i);
				end else begin
					want_addr   = exp_addr.pop_front();
					want_data   = exp_data.pop_front();
					accepted_at = exp_adv.pop_front();
					compare_word("wb_addr_o", {27'b0, want_addr}, {27'b0, wb_addr_i});
					compare_word("wb_data_o", want_data, wb_data_i);
					checks++;
					// Three pipeline registers plus the handshake edge
					if (adv_count - accepted_at != 4) begin
						errors++;
						$display("result for r%0d took %0d pipeline steps instead of 4",
							wb_addr_i, adv_count - accepted_at);
					end
				end
			end else if (exp_addr.size() != 0) begin
				idle_count++;
				if (idle_count == 200) begin
					errors++;
					$display("timeout: no writeback for 200 cycles with %0d results pending",
						exp_addr.size());
				end
			end
			if (inst_valid_i)
				seen_inst = 1'b1;
			if (inst_valid_i && inst_ready_i && reference_exec(inst_i, dest, value)) begin
				model[dest] = value;
				exp_addr.push_back(dest);
				exp_data.push_back(value);
				exp_adv.push_back(adv_count);
			end
			if (inst_ready_i)
				adv_count++;
			if (end_i && exp_addr.size() != 0) begin
				errors++;
				$display("%0d expected results were never written back", exp_addr.size());
			end
			stall_q = wb_valid_i && !wb_ready_i;
			addr_q  = wb_addr_i;
			data_q  = wb_data_i;
		end
		pending_o = exp_addr.size();
		errors_o  = errors;
		checks_o  = checks;
	end

endmodule

`default_nettype wire

/* verif/tb_mips_core.sv */
`default_nettype none

module tb_mips_core;
	timeunit 1ns;
	timeprecision 100ps;

	logic        clk;
	logic        rst_i;
	logic        inst_valid_i;
	logic [31:0] inst_i;
	logic        inst_ready_o;
	logic        wb_valid_o;
	logic [4:0]  wb_addr_o;
	logic [31:0] wb_data_o;
	logic        wb_ready_i;

	logic        taken;
	logic        random_ready;
	logic        run_done;
	logic [31:0] rng;
	int          tb_errors;
	int          pending;
	int          checker_errors;
	int          checks;

	mips_core mips_core_inst (
		.clk          (clk),
		.rst_i        (rst_i),
		.inst_valid_i (inst_valid_i),
		.inst_i       (inst_i),
		.inst_ready_o (inst_ready_o),
		.wb_valid_o   (wb_valid_o),
		.wb_addr_o    (wb_addr_o),
		.wb_data_o    (wb_data_o),
		.wb_ready_i   (wb_ready_i)
	);

	wb_checker checker_inst (
		.clk          (clk),
		.rst_i        (rst_i),
		.inst_valid_i (inst_valid_i),
		.inst_i       (inst_i),
		.inst_ready_i (inst_ready_o),
		.wb_valid_i   (wb_valid_o),
		.wb_addr_i    (wb_addr_o),
		.wb_data_i    (wb_data_o),
		.wb_ready_i   (wb_ready_i),
		.end_i        (run_done),
		.pending_o    (pending),
		.errors_o     (checker_errors),
		.checks_o     (checks)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Seen at the falling edge after the accepting edge
	always @(posedge clk) begin
		taken <= !rst_i && inst_valid_i && inst_ready_o;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] random_word();
		rng = xorshift32(rng);
		return rng;
	endfunction

	function automatic logic [31:0] encode_r(input logic [5:0] funct, input logic [4:0] rs,
			input logic [4:0] rt, input logic [4:0] rd, input logic [4:0] sa);
		return {mips_pkg::OP_SPECIAL, rs, rt, rd, sa, funct};
	endfunction

	function automatic logic [31:0] encode_i(input logic [5:0] op, input logic [4:0] rs,
			input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] random_instruction();
		logic [31:0] r;
		logic [31:0] k;
		logic [31:0] inst;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [4:0]  dest;
		r = random_word();
		k = random_word();
		// Eight registers keep dependencies dense
		rs   = {2'b00, r[2:0]};
		rt   = {2'b00, r[5:3]};
		dest = 5'd1 + ({2'b00, r[8:6]} % 5'd7);
		if (k[31:28] == 4'd1)
			dest = 5'd0;
		case (k[27:24])
			4'd0:  inst = encode_r(mips_pkg::FN_ADDU, rs, rt, dest, 5'd0);
			4'd1:  inst = encode_r(mips_pkg::FN_SUBU, rs, rt, dest, 5'd0);
			4'd2:  inst = encode_r(mips_pkg::FN_AND, rs, rt, dest, 5'd0);
			4'd3:  inst = encode_r(mips_pkg::FN_OR, rs, rt, dest, 5'd0);
			4'd4:  inst = encode_r(mips_pkg::FN_XOR, rs, rt, dest, 5'd0);
			4'd5:  inst = encode_r(mips_pkg::FN_NOR, rs, rt, dest, 5'd0);
			4'd7:  inst = encode_r(mips_pkg::FN_SLL, 5'd0, rt, dest, k[20:16]);
			4'd8:  inst = encode_r(mips_pkg::FN_SRL, 5'd0, rt, dest, k[20:16]);
			4'd9:  inst = encode_i(mips_pkg::OP_ADDIU, rs, dest, k[15:0]);
			4'd10: inst = encode_i(mips_pkg::OP_ANDI, rs, dest, k[15:0]);
			4'd11: inst = encode_i(mips_pkg::OP_ORI, rs, dest, k[15:0]);
			4'd12: inst = encode_i(mips_pkg::OP_XORI, rs, dest, k[15:0]);
			4'd13: inst = encode_i(mips_pkg::OP_LUI, 5'd0, dest, k[15:0]);
			4'd14: inst = encode_i(mips_pkg::OP_ADDIU, rs, dest, k[15:0]);
			default: inst = encode_r(mips_pkg::FN_SLT, rs, rt, dest, 5'd0);
		endcase
		// LW and MULT encodings are outside the kept set
		if (k[31:28] == 4'd0)
			inst = k[23] ? encode_i(6'b100011, rs, dest, k[15:0])
				: encode_r(6'b011000, rs, rt, dest, 5'd0);
		return inst;
	endfunction

	task automatic next_cycle();
		@(negedge clk);
		if (random_ready)
			wb_ready_i = (random_word() % 32'd10) < 32'd7;
	endtask

	task automatic present(input logic [31:0] inst);
		inst_valid_i = 1'b1;
		inst_i       = inst;
	endtask

	task automatic wait_accept();
		int waits;
		waits = 0;
		next_cycle();
		while (!taken && waits < 100) begin
			waits++;
			next_cycle();
		end
		if (!taken) begin
			tb_errors++;
			$display("timeout: instruction %h was never accepted", inst_i);
		end
		inst_valid_i = 1'b0;
	endtask

	task automatic send(input logic [31:0] inst);
		present(inst);
		wait_accept();
	endtask

	task automatic wait_drain();
		int waits;
		waits = 0;
		while (pending != 0 && waits < 300) begin
			waits++;
			next_cycle();
		end
		if (pending != 0) begin
			tb_errors++;
			$display("timeout: pipeline did not drain, %0d results pending", pending);
		end
		repeat (6) next_cycle();
	endtask

	initial begin
		rst_i        = 1'b1;
		inst_valid_i = 1'b0;
		inst_i       = '0;
		wb_ready_i   = 1'b1;
		random_ready = 1'b0;
		run_done     = 1'b0;
		rng          = 32'd36980;
		tb_errors    = 0;
		repeat (16) @(negedge clk);
		rst_i = 1'b0;
		repeat (4) next_cycle();

		// Single instruction through an empty pipeline
		send(encode_i(mips_pkg::OP_ORI, 5'd0, 5'd1, 16'h1234));
		wait_drain();

		// Back-to-back dependent chain
		send(encode_i(mips_pkg::OP_ADDIU, 5'd0, 5'd2, 16'hfffb));
		send(encode_i(mips_pkg::OP_ADDIU, 5'd2, 5'd3, 16'h0007));
		send(encode_i(mips_pkg::OP_ANDI, 5'd2, 5'd4, 16'h8f0f));
		send(encode_i(mips_pkg::OP_ORI, 5'd3, 5'd5, 16'h8000));
		send(encode_i(mips_pkg::OP_XORI, 5'd2, 5'd6, 16'hffff));
		send(encode_i(mips_pkg::OP_LUI, 5'd0, 5'd7, 16'h8001));
		send(encode_r(mips_pkg::FN_ADDU, 5'd2, 5'd3, 5'd1, 5'd0));
		send(encode_r(mips_pkg::FN_SUBU, 5'd1, 5'd7, 5'd1, 5'd0));
		send(encode_r(mips_pkg::FN_SLT, 5'd7, 5'd3, 5'd4, 5'd0));
		send(encode_r(mips_pkg::FN_SLT, 5'd3, 5'd7, 5'd5, 5'd0));
		send(encode_r(mips_pkg::FN_NOR, 5'd5, 5'd6, 5'd6, 5'd0));
		send(encode_r(mips_pkg::FN_XOR, 5'd6, 5'd1, 5'd5, 5'd0));
		send(encode_r(mips_pkg::FN_AND, 5'd5, 5'd2, 5'd4, 5'd0));
		send(encode_r(mips_pkg::FN_SLL, 5'd0, 5'd6, 5'd1, 5'd4));
		send(encode_r(mips_pkg::FN_SRL, 5'd0, 5'd1, 5'd2, 5'd3));
		send(32'hfc00_0000);
		send(encode_r(mips_pkg::FN_ADDU, 5'd1, 5'd2, 5'd0, 5'd0));
		send(encode_r(mips_pkg::FN_OR, 5'd0, 5'd2, 5'd3, 5'd0));
		wait_drain();

		// Fill the pipeline against a stalled consumer
		wb_ready_i = 1'b0;
		send(encode_i(mips_pkg::OP_ADDIU, 5'd3, 5'd1, 16'h0001));
		send(encode_i(mips_pkg::OP_ADDIU, 5'd1, 5'd2, 16'h0002));
		send(encode_i(mips_pkg::OP_ADDIU, 5'd2, 5'd3, 16'h0003));
		send(encode_i(mips_pkg::OP_ADDIU, 5'd3, 5'd4, 16'h0004));
		present(encode_r(mips_pkg::FN_ADDU, 5'd4, 5'd1, 5'd5, 5'd0));
		repeat (6) next_cycle();
		wb_ready_i = 1'b1;
		wait_accept();
		wait_drain();

		random_ready = 1'b1;
		for (int n = 0; n < 600; n++) begin
			if (random_word() % 32'd5 == 32'd0)
				next_cycle();
			send(random_instruction());
		end
		random_ready = 1'b0;
		wb_ready_i   = 1'b1;
		wait_drain();

		run_done = 1'b1;
		next_cycle();
		run_done = 1'b0;

		$display("checks %0d, checker errors %0d, testbench errors %0d",
			checks, checker_errors, tb_errors);
		if (checker_errors + tb_errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
source/mips_pkg.sv
source/regfile.sv
source/decode_stage.sv
source/execute_stage.sv
source/writeback_stage.sv
source/mips_core.sv
verif/wb_checker.sv
verif/tb_mips_core.sv

/* Makefile */
TOP := tb_mips_core

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps -f vlog.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f vlog.f \
		--top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^NO ERRORS$$" sim.log

clean:
	rm -rf obj_dir sim.log
